// File: verilog/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int NUM_SETS       = 256;
    localparam int WORDS_PER_LINE = 4;
    localparam int TAG_W          = 20;

    typedef logic [31:0]                    addr_t;   // byte address
    typedef logic [31:0]                    word_t;   // instruction word
    typedef logic [WORDS_PER_LINE*32-1:0]   line_t;   // word 0 in the low bits
    typedef logic [TAG_W-1:0]               tag_t;    // addr[31:12]
    typedef logic [7:0]                     index_t;  // addr[11:4]
    typedef logic [1:0]                     offset_t; // addr[3:2]

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  ready;  // one-cycle strobe
        word_t data;
    } fetch_rsp_t;

    typedef struct packed {
        logic  req;
        addr_t addr;   // line aligned
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        logic  ready;
        line_t line;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        ACCESS,
        WAIT_BUSY,
        REFILL,
        FILL
    } ctrl_state_t;

endpackage

// File: verilog/icache_way.sv
`timescale 1ns/1ps

module icache_way
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  index_t     index,     // set being read or filled
    input  logic       wr_en,     // fill strobe
    input  tag_entry_t wr_entry,
    input  line_t      wr_line,
    output tag_entry_t rd_entry,
    output line_t      rd_line
);

    logic [NUM_SETS-1:0] valid_q;             // per-set valid bits
    tag_t                tag_q  [NUM_SETS];
    line_t               data_q [NUM_SETS];

    // valid bits are the only state cleared at reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[index] <= wr_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[index]  <= wr_entry.tag;
            data_q[index] <= wr_line;
        end
    end

    // asynchronous read port
    always_comb begin
        rd_entry.valid = valid_q[index];
        rd_entry.tag   = tag_q[index];
    end

    assign rd_line = data_q[index];

endmodule

// File: verilog/icache_lru.sv
`timescale 1ns/1ps

module icache_lru
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  index_t index,
    input  logic   update,    // hit or fill in this set
    input  logic   used_way,  // way just touched
    output logic   lru_way    // way to replace next
);

    logic [NUM_SETS-1:0] lru_q;

    // the stored bit always names the way that was not used last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (update) begin
            lru_q[index] <= ~used_way;
        end
    end

    assign lru_way = lru_q[index];

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // fetch side
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    output logic       stall,
    // way and lru arrays
    output index_t     index,
    input  tag_entry_t entry0,
    input  tag_entry_t entry1,
    input  line_t      line0,
    input  line_t      line1,
    input  logic       lru_way,
    output logic       lru_update,
    output logic       used_way,
    output logic       wr_en0,
    output logic       wr_en1,
    output tag_entry_t wr_entry,
    // next-level memory
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp,
    output line_t      fill_line
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;

    logic    hit0;
    logic    hit1;
    logic    hit;
    line_t   hit_line;
    word_t   hit_word;
    logic    access_miss;   // valid fetch missing in ACCESS
    logic    victim;

    addr_t   miss_addr;     // line address of the pending miss
    line_t   fill_buf;      // line returned by memory

    // split the fetch address
    assign req_tag    = fetch_req.addr[31:12];
    assign req_index  = fetch_req.addr[11:4];
    assign req_offset = fetch_req.addr[3:2];

    // the arrays follow the fetch address until a miss is pending
    assign index = (state == IDLE || state == ACCESS) ? req_index : miss_addr[11:4];

    // tag compare on both ways
    assign hit0 = entry0.valid && (entry0.tag == req_tag);
    assign hit1 = entry1.valid && (entry1.tag == req_tag);
    assign hit  = hit0 || hit1;

    always_comb begin
        hit_line = hit1 ? line1 : line0;
        hit_word = hit_line[{req_offset, 5'd0} +: 32];  // word at offset
    end

    assign access_miss = (state == ACCESS) && fetch_req.valid && !hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                next_state = ACCESS;
            end
            ACCESS: begin
                if (access_miss) begin
                    next_state = mem_rsp.busy ? WAIT_BUSY : REFILL;
                end
            end
            WAIT_BUSY: begin
                if (!mem_rsp.busy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp.ready) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                next_state = ACCESS;  // retried fetch hits now
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // miss address and returned line
    always_ff @(posedge clk) begin
        if (access_miss) begin
            miss_addr <= {fetch_req.addr[31:4], 4'b0000};
        end
        if (state == REFILL && mem_rsp.ready) begin
            fill_buf <= mem_rsp.line;
        end
    end

    // zero-latency fetch response on a hit
    assign fetch_rsp.ready = (state == ACCESS) && fetch_req.valid && hit;
    assign fetch_rsp.data  = hit_word;

    assign stall = access_miss || (state == WAIT_BUSY) || (state == REFILL) ||
                   (state == FILL);

    // request is held for the whole REFILL state
    assign mem_req.req  = (state == REFILL);
    assign mem_req.addr = miss_addr;

    // invalid ways first, then the lru choice
    always_comb begin
        if (!entry0.valid) begin
            victim = 1'b0;
        end else if (!entry1.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru_way;
        end
    end

    assign wr_en0         = (state == FILL) && !victim;
    assign wr_en1         = (state == FILL) && victim;
    assign wr_entry.valid = 1'b1;
    assign wr_entry.tag   = miss_addr[31:12];
    assign fill_line      = fill_buf;

    assign lru_update = fetch_rsp.ready || (state == FILL);
    assign used_way   = (state == FILL) ? victim : hit1;

    // the missing line is in neither way when it is filled
    a_fill_new_line: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FILL) |-> !(entry0.valid && entry0.tag == wr_entry.tag) &&
                            !(entry1.valid && entry1.tag == wr_entry.tag));

    // request and address held until the memory answers
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.req && !mem_rsp.ready |=> mem_req.req && $stable(mem_req.addr));

    // a line lives in at most one way
    a_no_double_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ACCESS && fetch_req.valid) |-> !(hit0 && hit1));

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    output logic       stall,      // miss in progress
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    index_t     index;
    tag_entry_t entry0;
    tag_entry_t entry1;
    line_t      line0;
    line_t      line1;
    logic       lru_way;
    logic       lru_update;
    logic       used_way;
    logic       wr_en0;
    logic       wr_en1;
    tag_entry_t wr_entry;   // shared by both ways
    line_t      fill_line;

    icache_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .stall      (stall),
        .index      (index),
        .entry0     (entry0),
        .entry1     (entry1),
        .line0      (line0),
        .line1      (line1),
        .lru_way    (lru_way),
        .lru_update (lru_update),
        .used_way   (used_way),
        .wr_en0     (wr_en0),
        .wr_en1     (wr_en1),
        .wr_entry   (wr_entry),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .fill_line  (fill_line)
    );

    icache_way way0_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .wr_en    (wr_en0),
        .wr_entry (wr_entry),
        .wr_line  (fill_line),
        .rd_entry (entry0),
        .rd_line  (line0)
    );

    icache_way way1_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .wr_en    (wr_en1),
        .wr_entry (wr_entry),
        .wr_line  (fill_line),
        .rd_entry (entry1),
        .rd_line  (line1)
    );

    icache_lru lru_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .update   (lru_update),
        .used_way (used_way),
        .lru_way  (lru_way)
    );

endmodule

// File: test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold_busy,   // forces busy while idle
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp,
    output int       req_count    // requests served
);

    localparam word_t DATA_KEY = 32'h5a3c_96e1;

    integer seed;
    int     wait_cnt;   // cycles left until ready
    addr_t  line_addr;
    logic   in_reset;     // reset seen at the clock edge
    logic   force_busy;   // hold_busy seen at the clock edge

    // each word is its own address xor a key
    function automatic line_t line_data(input addr_t addr);
        line_t data;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            data[i*32 +: 32] = (addr + addr_t'(i * 4)) ^ DATA_KEY;
        end
        return data;
    endfunction

    initial begin
        seed      = 32'haf59;
        mem_rsp   = '0;
        req_count = 0;
        wait_cnt  = 0;
        line_addr = '0;
        forever begin
            @(posedge clk);
            in_reset   = !rst_n;
            force_busy = hold_busy;
            #1;
            if (in_reset) begin
                mem_rsp  = '0;
                wait_cnt = 0;
            end else if (mem_rsp.ready) begin
                mem_rsp.ready = 1'b0;   // one-cycle strobe
            end else if (wait_cnt != 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    mem_rsp.ready = 1'b1;
                    mem_rsp.line  = line_data(line_addr);
                    req_count     = req_count + 1;
                end
            end else if (mem_req.req) begin
                mem_rsp.busy = 1'b0;
                line_addr    = mem_req.addr;
                wait_cnt     = 2 + int'($unsigned($random(seed)) % 8);   // 2 to 9 cycles
            end else begin
                mem_rsp.busy = force_busy || ($random(seed) % 4 == 0);   // busy on random cycles
            end
        end
    end

endmodule

// File: test/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam word_t DATA_KEY = 32'h5a3c_96e1;
    localparam int    TIMEOUT  = 200;

    logic       clk;
    logic       rst_n;
    logic       hold_busy;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    logic       stall;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    int         req_count;

    integer seed;
    int     errors;
    int     tests_passed;
    int     tests_failed;

    logic   ref_valid [2][NUM_SETS];   // reference cache state
    tag_t   ref_tag   [2][NUM_SETS];
    logic   ref_lru   [NUM_SETS];

    logic   last_hit;       // ready in the first cycle
    logic   last_stall;     // stall in the first cycle
    addr_t  last_mem_addr;
    word_t  last_data;

    icache_top dut_i (.clk(clk), .rst_n(rst_n), .fetch_req(fetch_req), .fetch_rsp(fetch_rsp),
                      .stall(stall), .mem_req(mem_req), .mem_rsp(mem_rsp));

    tb_mem_model mem_i (.clk(clk), .rst_n(rst_n), .hold_busy(hold_busy), .mem_req(mem_req),
                        .mem_rsp(mem_rsp), .req_count(req_count));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t mem_word(input addr_t addr);
        return {addr[31:2], 2'b00} ^ DATA_KEY;
    endfunction

    function automatic int ref_way(input addr_t addr);   // -1 on a miss
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][addr[11:4]] && ref_tag[w][addr[11:4]] == addr[31:12]) return w;
        end
        return -1;
    endfunction

    task automatic ref_access(input addr_t addr);
        int     w;
        index_t idx;
        idx = addr[11:4];
        w   = ref_way(addr);
        if (w < 0) begin
            if (!ref_valid[0][idx]) w = 0;
            else if (!ref_valid[1][idx]) w = 1;
            else w = int'(ref_lru[idx]);
            ref_valid[w][idx] = 1'b1;
            ref_tag[w][idx]   = addr[31:12];
        end
        ref_lru[idx] = (w == 0);   // points at the other way
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    // holds the request until ready, sampling at the falling edge
    task automatic do_fetch(input addr_t addr);
        int   cycles;
        logic done;
        cycles          = 0;
        done            = 1'b0;
        last_hit        = 1'b1;
        last_mem_addr   = '0;
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            if (cycles == 0) last_stall = stall;
            if (mem_req.req) last_mem_addr = mem_req.addr;
            if (fetch_rsp.ready) begin
                done      = 1'b1;
                last_data = fetch_rsp.data;
            end else begin
                last_hit = 1'b0;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        fetch_req.valid = 1'b0;
        if (!done) begin
            $display("timeout: no ready within %0d cycles for address %h", TIMEOUT, addr);
            errors++;
        end
    endtask

    task automatic checked_fetch(input addr_t addr);
        logic predicted;
        int   count_before;
        predicted    = (ref_way(addr) >= 0);
        count_before = req_count;
        do_fetch(addr);
        check_value("fetch_rsp.ready at request", 32'(predicted), 32'(last_hit));
        check_value("fetch_rsp.data", mem_word(addr), last_data);
        check_value("stall at request", 32'(!predicted), 32'(last_stall));
        check_value("req_count", count_before + (predicted ? 0 : 1), req_count);
        if (!predicted) check_value("mem_req.addr", {addr[31:4], 4'h0}, last_mem_addr);
        ref_access(addr);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        int          errors_before;
        logic [31:0] r;
        logic [31:0] tags;
        logic [7:0]  hits;
        addr_t       addr;
        seed         = 32'haf59;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        hold_busy    = 1'b0;
        fetch_req    = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);   // IDLE to ACCESS
        #1;

        errors_before = errors;
        @(negedge clk);
        check_value("fetch_rsp.ready", 0, 32'(fetch_rsp.ready));
        check_value("stall", 0, 32'(stall));
        check_value("mem_req.req", 0, 32'(mem_req.req));
        @(posedge clk);
        #1;
        checked_fetch(32'h0000_1008);   // cold miss
        finish_test("reset state", errors_before);

        errors_before = errors;
        repeat (300) begin
            r = $random(seed);
            checked_fetch({18'h00010, r[1:0], 6'h00, r[3:2], r[5:4], 2'b00});
        end
        finish_test("random data", errors_before);

        errors_before = errors;
        repeat (50) begin
            r    = $random(seed);
            addr = {18'h00010, r[1:0], 6'h00, r[3:2], r[5:4], 2'b00};
            checked_fetch(addr);
            checked_fetch(addr);
            check_value("fetch_rsp.ready at repeat", 1, 32'(last_hit));
        end
        finish_test("hit behavior", errors_before);

        // tags A B A C A B C A in set 0x20
        errors_before = errors;
        tags = {4'h1, 4'h2, 4'h1, 4'h3, 4'h1, 4'h2, 4'h3, 4'h1};
        hits = 8'b0010_1000;
        for (int i = 0; i < 8; i++) begin
            addr = {12'h000, tags[31-4*i -: 4], 16'h0200};
            check_value("predicted hit", 32'(hits[7-i]), 32'(ref_way(addr) >= 0));
            checked_fetch(addr);
        end
        finish_test("replacement", errors_before);

        errors_before = errors;
        hold_busy = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        addr            = 32'h0004_0300;
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        repeat (10) begin
            @(negedge clk);
            check_value("mem_req.req", 0, 32'(mem_req.req));
            check_value("stall", 1, 32'(stall));
            check_value("mem_rsp.busy", 1, 32'(mem_rsp.busy));
            @(posedge clk);
            #1;
        end
        hold_busy = 1'b0;
        checked_fetch(addr);
        finish_test("busy back-pressure", errors_before);

        errors_before = errors;
        checked_fetch(32'h0005_0400);
        for (int o = 0; o < 4; o++) begin
            addr = 32'h0005_0400 + addr_t'(o * 4);
            checked_fetch(addr);
            check_value("fetch_rsp.ready at offset", 1, 32'(last_hit));
        end
        finish_test("word select", errors_before);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: icache.f
verilog/icache_pkg.sv
verilog/icache_way.sv
verilog/icache_lru.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/tb_mem_model.sv
test/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f icache.f --top-module tb_icache -o sim_icache \
    && ./obj_dir/sim_icache > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -qsx "Everything OK" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
